//--- dmem_sys.f
rtl/dmem_pkg.sv
rtl/dmem_router.sv
rtl/dmem_tcm.sv
rtl/dmem_timer.sv
rtl/dmem_sys_top.sv
dv/dmem_sys_assertions.sv
dv/dmem_sys_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the data memory subsystem simulation with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wall -Wno-fatal \
    -f dmem_sys.f --top-module dmem_sys_tb -Mdir "$OBJ" -o Vdmem_sys_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ/Vdmem_sys_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^All checks passed$" "$LOG"; then
    exit 0
else
    echo "Pass message not found in $LOG"
    exit 1
fi

//--- dv/dmem_sys_tb.sv
// Testbench for the data memory subsystem
// Core driver, external memory model, reference models and watchdog

`timescale 1ns/100ps

module dmem_sys_tb import dmem_pkg::*;;

    // Transactions issued by the test sequence
    localparam int NUM_TXNS = 71;
    localparam int DEPTH    = 256;

    logic clk, rst_n, dmem_req, dmem_cmd, dmem_req_ack;
    dmem_width_t dmem_width, ext_width, cur_width;
    dmem_addr_t  dmem_addr, ext_addr, cur_addr;
    dmem_data_t  dmem_wdata, dmem_rdata, ext_wdata, ext_rdata, cur_wdata;
    dmem_resp_t  dmem_resp, ext_resp;
    logic ext_req, ext_cmd, ext_req_ack, timer_irq;
    logic cur_cmd;

    integer     seed = 32'h4caa7aa9;
    int         errors = 0;
    int         checks = 0;
    int         txn_count = 0;
    dmem_data_t tcm_ref [DEPTH];
    dmem_data_t ext_ref [DEPTH];
    dmem_data_t ext_mem [DEPTH];

    dmem_sys_top i_dmem_sys_top (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic dmem_data_t merge_lanes(dmem_data_t old, dmem_data_t wd,
                                               dmem_width_t w, dmem_addr_t a);
        dmem_data_t mask;
        case (w)
            MEM_WIDTH_BYTE:  mask = 32'h0000_00FF << (8 * a[1:0]);
            MEM_WIDTH_HWORD: mask = 32'h0000_FFFF << (8 * a[1:0]);
            default:         mask = 32'hFFFF_FFFF;
        endcase
        return (old & ~mask) | (wd & mask);
    endfunction

    function automatic logic misaligned(dmem_width_t w, dmem_addr_t a);
        return (w == MEM_WIDTH_HWORD && a[0]) || (w == MEM_WIDTH_WORD && a[1:0] != 2'b00);
    endfunction

    // One-hot of {ext, timer, tcm} with the timer window checked first
    function automatic logic [2:0] route_of(dmem_addr_t a);
        if ((a & 32'hFFFF0000) == 32'h00010000) return 3'b010;
        if ((a & 32'hFFFF0000) == 32'h00020000) return 3'b100;
        return 3'b001;
    endfunction

    task automatic check_value(string name, dmem_data_t exp, dmem_data_t act);
        checks++;
        assert (exp === act) else begin
            $display("** Error %s: expected %08h, actual %08h", name, exp, act);
            errors++;
        end
    endtask

    // ------------------------------------------------------------------
    // Core-side driver
    // ------------------------------------------------------------------
    task automatic access(string name, logic c, dmem_width_t w, dmem_addr_t a,
                          dmem_data_t wd, output dmem_resp_t r, output dmem_data_t rd);
        logic accepted;
        @(posedge clk);
        #1;
        cur_cmd    = c;
        cur_width  = w;
        cur_addr   = a;
        cur_wdata  = wd;
        dmem_req   = 1'b1;
        dmem_cmd   = c;
        dmem_width = w;
        dmem_addr  = a;
        dmem_wdata = wd;
        do begin
            @(negedge clk);
            check_value({name, " route"}, route_of(a),
                        {ext_req, i_dmem_sys_top.timer_req, i_dmem_sys_top.tcm_req});
            accepted = dmem_req_ack;
            @(posedge clk);
        end while (!accepted);
        #1 dmem_req = 1'b0;
        do @(negedge clk); while (dmem_resp == MEM_RESP_NOTRDY);
        r  = dmem_resp;
        rd = dmem_rdata;
        txn_count++;
    endtask

    // Write to TCM or external memory and track the reference model
    task automatic mem_write(string name, dmem_width_t w, dmem_addr_t a, dmem_data_t wd);
        dmem_resp_t r;
        dmem_data_t rd;
        access(name, MEM_CMD_WR, w, a, wd, r, rd);
        check_value({name, " resp"}, misaligned(w, a) ? MEM_RESP_RDY_ER : MEM_RESP_RDY_OK, r);
        if (!misaligned(w, a)) begin
            if (route_of(a) == 3'b100)
                ext_ref[a[9:2]] = merge_lanes(ext_ref[a[9:2]], wd, w, a);
            else
                tcm_ref[a[9:2]] = merge_lanes(tcm_ref[a[9:2]], wd, w, a);
        end
    endtask

    task automatic mem_read(string name, dmem_addr_t a);
        dmem_resp_t r;
        dmem_data_t rd;
        access(name, MEM_CMD_RD, MEM_WIDTH_WORD, a, '0, r, rd);
        check_value({name, " resp"}, MEM_RESP_RDY_OK, r);
        check_value(name, (route_of(a) == 3'b100) ? ext_ref[a[9:2]] : tcm_ref[a[9:2]], rd);
    endtask

    task automatic expect_resp(string name, logic c, dmem_width_t w, dmem_addr_t a,
                               dmem_data_t wd, dmem_resp_t exp, output dmem_data_t rd);
        dmem_resp_t r;
        access(name, c, w, a, wd, r, rd);
        check_value({name, " resp"}, exp, r);
    endtask

    // Word reads issued on consecutive cycles
    task automatic burst_read(string name, int n);
        @(posedge clk);
        for (int i = 0; i <= n; i++) begin
            #1;
            dmem_req   = (i < n);
            dmem_cmd   = MEM_CMD_RD;
            dmem_width = MEM_WIDTH_WORD;
            dmem_addr  = 32'(4 * i);
            @(negedge clk);
            if (i < n) begin
                check_value({name, " ack"}, 1, dmem_req_ack);
            end
            if (i > 0) begin
                check_value({name, " resp"}, MEM_RESP_RDY_OK, dmem_resp);
                check_value(name, tcm_ref[i-1], dmem_rdata);
            end
            @(posedge clk);
            if (i < n) begin
                txn_count++;
            end
        end
    endtask

    // ------------------------------------------------------------------
    // External memory model
    // ------------------------------------------------------------------
    initial begin
        int          dly;
        logic        c;
        dmem_width_t w;
        dmem_addr_t  a;
        dmem_data_t  wd;
        ext_req_ack = 1'b0;
        ext_resp    = MEM_RESP_NOTRDY;
        ext_rdata   = '0;
        for (int i = 0; i < DEPTH; i++) begin
            ext_mem[i] = (32'h00020000 + 4 * i) ^ 32'h5A3C_96E1;
            ext_ref[i] = ext_mem[i];
        end
        forever begin
            // Ack wait for the next request, zero means ready in advance
            dly = {$random(seed)} % 4;
            ext_req_ack = (dly == 0);
            do @(negedge clk); while (!ext_req);
            check_value("ext cmd", cur_cmd, ext_cmd);
            check_value("ext width", cur_width, ext_width);
            check_value("ext addr", cur_addr, ext_addr);
            if (ext_cmd == MEM_CMD_WR) begin
                check_value("ext wdata", cur_wdata, ext_wdata);
            end
            c  = ext_cmd;
            w  = ext_width;
            a  = ext_addr;
            wd = ext_wdata;
            if (dly > 0) begin
                repeat (dly) @(posedge clk);
                #1 ext_req_ack = 1'b1;
            end
            // Acceptance edge
            @(posedge clk);
            #1;
            // Random ack level while busy
            ext_req_ack = (({$random(seed)} % 2) == 1);
            dly = 1 + {$random(seed)} % 4;
            repeat (dly - 1) begin
                @(posedge clk);
                #1;
            end
            if (misaligned(w, a)) begin
                ext_resp = MEM_RESP_RDY_ER;
            end else begin
                ext_resp = MEM_RESP_RDY_OK;
                if (c == MEM_CMD_WR) begin
                    ext_mem[a[9:2]] = merge_lanes(ext_mem[a[9:2]], wd, w, a);
                end else begin
                    ext_rdata = ext_mem[a[9:2]];
                end
            end
            @(posedge clk);
            #1 ext_resp = MEM_RESP_NOTRDY;
        end
    end

    // Watchdog
    initial begin
        #(NUM_TXNS * 10 * 20 + 2000);
        $display("Watchdog timeout after %0d transactions", txn_count);
        $display("Checks failed");
        $finish;
    end

    // ------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------
    initial begin
        dmem_data_t rd, t0, t1;
        rst_n = 1'b0;
        dmem_req = 1'b0;
        dmem_cmd = MEM_CMD_RD;
        dmem_width = MEM_WIDTH_WORD;
        dmem_addr = '0;
        dmem_wdata = '0;
        cur_cmd = MEM_CMD_RD;
        cur_width = MEM_WIDTH_WORD;
        cur_addr = '0;
        cur_wdata = '0;
        repeat (10) @(posedge clk);
        #1 rst_n = 1'b1;
        @(negedge clk);
        check_value("irq after reset", 0, timer_irq);

        // TCM read-back and aliasing
        for (int i = 0; i < 8; i++) begin
            mem_write("tcm word wr", MEM_WIDTH_WORD, 4 * i, 32'h1111_1111 * (i + 1));
        end
        mem_write("tcm byte wr", MEM_WIDTH_BYTE, 32'h1, 32'hAAAA_BBCC);
        mem_write("tcm hword wr", MEM_WIDTH_HWORD, 32'h6, 32'hDEAD_BEEF);
        mem_write("tcm byte wr", MEM_WIDTH_BYTE, 32'h13, 32'h9900_0000);
        for (int i = 0; i < 8; i++) begin
            mem_read("tcm read", 4 * i);
        end
        mem_read("tcm alias read", 32'h408);
        mem_write("tcm alias wr", MEM_WIDTH_WORD, 32'h40C, 32'hC0DE_0001);
        mem_read("tcm alias read", 32'hC);

        // TCM misalignment
        expect_resp("tcm hword odd", MEM_CMD_WR, MEM_WIDTH_HWORD, 32'h3, 32'hFFFF_FFFF,
                    MEM_RESP_RDY_ER, rd);
        expect_resp("tcm word unal", MEM_CMD_WR, MEM_WIDTH_WORD, 32'h2, 32'hFFFF_FFFF,
                    MEM_RESP_RDY_ER, rd);
        expect_resp("tcm rd unal", MEM_CMD_RD, MEM_WIDTH_WORD, 32'h1, '0,
                    MEM_RESP_RDY_ER, rd);
        mem_read("tcm unchanged", 32'h0);

        // Timer registers
        expect_resp("timer mtime wr", MEM_CMD_WR, MEM_WIDTH_WORD, 32'h10004, 32'd100,
                    MEM_RESP_RDY_OK, rd);
        expect_resp("timer cmp wr", MEM_CMD_WR, MEM_WIDTH_WORD, 32'h10008, 32'd50,
                    MEM_RESP_RDY_OK, rd);
        expect_resp("timer mtime rd", MEM_CMD_RD, MEM_WIDTH_WORD, 32'h10004, '0,
                    MEM_RESP_RDY_OK, rd);
        check_value("timer mtime", 32'd100, rd);
        expect_resp("timer cmp rd", MEM_CMD_RD, MEM_WIDTH_WORD, 32'h10008, '0,
                    MEM_RESP_RDY_OK, rd);
        check_value("timer cmp", 32'd50, rd);
        expect_resp("timer enable", MEM_CMD_WR, MEM_WIDTH_WORD, 32'h10000, 32'd1,
                    MEM_RESP_RDY_OK, rd);
        @(negedge clk);
        check_value("irq set", 1, timer_irq);
        expect_resp("timer cmp high", MEM_CMD_WR, MEM_WIDTH_WORD, 32'h10008, 32'h8000_0000,
                    MEM_RESP_RDY_OK, rd);
        @(negedge clk);
        check_value("irq clear", 0, timer_irq);
        expect_resp("timer mtime rd1", MEM_CMD_RD, MEM_WIDTH_WORD, 32'h10004, '0,
                    MEM_RESP_RDY_OK, t0);
        expect_resp("timer mtime rd2", MEM_CMD_RD, MEM_WIDTH_WORD, 32'h10004, '0,
                    MEM_RESP_RDY_OK, t1);
        check_value("mtime increasing", 1, t1 > t0);

        // Timer errors
        expect_resp("timer byte", MEM_CMD_RD, MEM_WIDTH_BYTE, 32'h10000, '0,
                    MEM_RESP_RDY_ER, rd);
        expect_resp("timer ofs c", MEM_CMD_WR, MEM_WIDTH_WORD, 32'h1000C, 32'd7,
                    MEM_RESP_RDY_ER, rd);

        // External port under random back-pressure
        for (int i = 0; i < 24; i++) begin
            dmem_addr_t a;
            a = 32'h00020000 + 4 * ({$random(seed)} % 16);
            if ({$random(seed)} % 2) begin
                mem_write("ext wr", MEM_WIDTH_WORD, a, $random(seed));
            end else begin
                mem_read("ext rd", a);
            end
        end
        mem_write("ext byte wr", MEM_WIDTH_BYTE, 32'h00020006, 32'h0077_0000);
        mem_write("ext unal wr", MEM_WIDTH_WORD, 32'h00020005, 32'hFFFF_FFFF);
        mem_read("ext rd", 32'h00020004);

        // Back-to-back TCM reads
        burst_read("tcm burst", 8);

        if (errors == 0) begin
            $display("Checks: %0d, errors: %0d, transactions: %0d", checks, errors, txn_count);
            $display("All checks passed");
        end else begin
            $display("Checks: %0d, errors: %0d, transactions: %0d", checks, errors, txn_count);
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- dv/dmem_sys_assertions.sv
// Protocol assertions for the data memory router
// Bound to every dmem_router instance

`timescale 1ns/100ps

module dmem_sys_assertions import dmem_pkg::*; (
    input logic        clk,
    input logic        rst_n,
    input logic        dmem_req,
    input logic        dmem_cmd,
    input dmem_width_t dmem_width,
    input dmem_addr_t  dmem_addr,
    input logic        dmem_req_ack,
    input dmem_resp_t  dmem_resp,
    input logic        port0_req,
    input logic        port1_req,
    input logic        port2_req
);

    // Data phase seen from the core side
    logic data_phase;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            data_phase <= 1'b0;
        end else if (dmem_req && dmem_req_ack) begin
            data_phase <= 1'b1;
        end else if (dmem_resp != MEM_RESP_NOTRDY) begin
            data_phase <= 1'b0;
        end
    end

    // ------------------------------------------------------------------
    a_one_port_req: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({port0_req, port1_req, port2_req}))
        else $error("more than one port request in the same cycle");

    a_no_ack_notrdy: assert property (@(posedge clk) disable iff (!rst_n)
        (data_phase && dmem_resp == MEM_RESP_NOTRDY) |-> !dmem_req_ack)
        else $error("request acknowledged while the data phase is not ready");

    a_fields_known: assert property (@(posedge clk) disable iff (!rst_n)
        dmem_req |-> !$isunknown({dmem_cmd, dmem_width, dmem_addr}))
        else $error("request fields unknown while req is high");

    a_idle_no_req: assert property (@(posedge clk) disable iff (!rst_n)
        !dmem_req |-> !(port0_req || port1_req || port2_req))
        else $error("port request without a core request");

endmodule

bind dmem_router dmem_sys_assertions i_dmem_sys_assertions (
    .clk          (clk),
    .rst_n        (rst_n),
    .dmem_req     (dmem_req),
    .dmem_cmd     (dmem_cmd),
    .dmem_width   (dmem_width),
    .dmem_addr    (dmem_addr),
    .dmem_req_ack (dmem_req_ack),
    .dmem_resp    (dmem_resp),
    .port0_req    (port0_req),
    .port1_req    (port1_req),
    .port2_req    (port2_req)
);

//--- rtl/dmem_sys_top.sv
// Data memory subsystem top level
// Router, TCM and timer, with port 2 exported as the external port

`timescale 1ns/100ps

module dmem_sys_top import dmem_pkg::*; #(
    parameter int         TCM_DEPTH_WORDS    = 256,
    parameter dmem_addr_t TIMER_ADDR_MASK    = 32'hFFFF0000,
    parameter dmem_addr_t TIMER_ADDR_PATTERN = 32'h00010000,
    parameter dmem_addr_t EXT_ADDR_MASK      = 32'hFFFF0000,
    parameter dmem_addr_t EXT_ADDR_PATTERN   = 32'h00020000
) (
    input  logic        clk,
    input  logic        rst_n,

    // Core side
    input  logic        dmem_req,
    input  logic        dmem_cmd,
    input  dmem_width_t dmem_width,
    input  dmem_addr_t  dmem_addr,
    input  dmem_data_t  dmem_wdata,
    output logic        dmem_req_ack,
    output dmem_data_t  dmem_rdata,
    output dmem_resp_t  dmem_resp,

    // External memory port
    output logic        ext_req,
    output logic        ext_cmd,
    output dmem_width_t ext_width,
    output dmem_addr_t  ext_addr,
    output dmem_data_t  ext_wdata,
    input  logic        ext_req_ack,
    input  dmem_data_t  ext_rdata,
    input  dmem_resp_t  ext_resp,

    output logic        timer_irq
);

    // ---------------------------------------------------------------------
    // Router to TCM and timer
    // ---------------------------------------------------------------------
    logic        tcm_req;
    logic        tcm_cmd;
    dmem_width_t tcm_width;
    dmem_addr_t  tcm_addr;
    dmem_data_t  tcm_wdata;
    logic        tcm_req_ack;
    dmem_data_t  tcm_rdata;
    dmem_resp_t  tcm_resp;

    logic        timer_req;
    logic        timer_cmd;
    dmem_width_t timer_width;
    dmem_addr_t  timer_addr;
    dmem_data_t  timer_wdata;
    logic        timer_req_ack;
    dmem_data_t  timer_rdata;
    dmem_resp_t  timer_resp;

    dmem_router #(
        .PORT1_ADDR_MASK    (TIMER_ADDR_MASK),
        .PORT1_ADDR_PATTERN (TIMER_ADDR_PATTERN),
        .PORT2_ADDR_MASK    (EXT_ADDR_MASK),
        .PORT2_ADDR_PATTERN (EXT_ADDR_PATTERN)
    ) i_dmem_router (
        .clk           (clk),
        .rst_n         (rst_n),
        .dmem_req      (dmem_req),
        .dmem_cmd      (dmem_cmd),
        .dmem_width    (dmem_width),
        .dmem_addr     (dmem_addr),
        .dmem_wdata    (dmem_wdata),
        .dmem_req_ack  (dmem_req_ack),
        .dmem_rdata    (dmem_rdata),
        .dmem_resp     (dmem_resp),
        .port0_req     (tcm_req),
        .port0_cmd     (tcm_cmd),
        .port0_width   (tcm_width),
        .port0_addr    (tcm_addr),
        .port0_wdata   (tcm_wdata),
        .port0_req_ack (tcm_req_ack),
        .port0_rdata   (tcm_rdata),
        .port0_resp    (tcm_resp),
        .port1_req     (timer_req),
        .port1_cmd     (timer_cmd),
        .port1_width   (timer_width),
        .port1_addr    (timer_addr),
        .port1_wdata   (timer_wdata),
        .port1_req_ack (timer_req_ack),
        .port1_rdata   (timer_rdata),
        .port1_resp    (timer_resp),
        .port2_req     (ext_req),
        .port2_cmd     (ext_cmd),
        .port2_width   (ext_width),
        .port2_addr    (ext_addr),
        .port2_wdata   (ext_wdata),
        .port2_req_ack (ext_req_ack),
        .port2_rdata   (ext_rdata),
        .port2_resp    (ext_resp)
    );

    dmem_tcm #(
        .TCM_DEPTH_WORDS (TCM_DEPTH_WORDS)
    ) i_dmem_tcm (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (tcm_req),
        .cmd     (tcm_cmd),
        .width   (tcm_width),
        .addr    (tcm_addr),
        .wdata   (tcm_wdata),
        .req_ack (tcm_req_ack),
        .rdata   (tcm_rdata),
        .resp    (tcm_resp)
    );

    dmem_timer i_dmem_timer (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (timer_req),
        .cmd     (timer_cmd),
        .width   (timer_width),
        .addr    (timer_addr),
        .wdata   (timer_wdata),
        .req_ack (timer_req_ack),
        .rdata   (timer_rdata),
        .resp    (timer_resp),
        .irq     (timer_irq)
    );

endmodule

//--- rtl/dmem_timer.sv
// Memory-mapped machine timer
// CTRL, MTIME and MTIMECMP registers with compare interrupt

`timescale 1ns/100ps

module dmem_timer import dmem_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        req,
    input  logic        cmd,
    input  dmem_width_t width,
    input  dmem_addr_t  addr,
    input  dmem_data_t  wdata,
    output logic        req_ack,
    output dmem_data_t  rdata,
    output dmem_resp_t  resp,
    output logic        irq
);

    // Register offsets inside the timer window
    localparam logic [3:0] OFS_CTRL     = 4'h0;
    localparam logic [3:0] OFS_MTIME    = 4'h4;
    localparam logic [3:0] OFS_MTIMECMP = 4'h8;

    logic       timer_en;
    dmem_data_t mtime;
    dmem_data_t mtimecmp;
    logic       reg_hit;
    logic       access_err;
    logic       accept;
    logic       do_write;

    assign accept = req & req_ack;

    always_comb begin
        case (addr[3:0])
            OFS_CTRL, OFS_MTIME, OFS_MTIMECMP: reg_hit = 1'b1;
            default:                           reg_hit = 1'b0;
        endcase
    end

    // Word accesses only
    assign access_err = (width != MEM_WIDTH_WORD) | ~reg_hit;
    assign do_write   = accept & ~access_err & (cmd == MEM_CMD_WR);

    // ---------------------------------------------------------------------
    // Handshake, registers and counter
    // ---------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            req_ack  <= 1'b0;
            resp     <= MEM_RESP_NOTRDY;
            timer_en <= 1'b0;
            mtime    <= '0;
            mtimecmp <= '1;
        end else begin
            req_ack <= 1'b1;
            if (accept) begin
                resp <= access_err ? MEM_RESP_RDY_ER : MEM_RESP_RDY_OK;
            end else begin
                resp <= MEM_RESP_NOTRDY;
            end

            if (do_write && (addr[3:0] == OFS_CTRL)) begin
                timer_en <= wdata[0];
            end
            if (do_write && (addr[3:0] == OFS_MTIMECMP)) begin
                mtimecmp <= wdata;
            end

            // A write to MTIME beats the increment
            if (do_write && (addr[3:0] == OFS_MTIME)) begin
                mtime <= wdata;
            end else if (timer_en) begin
                mtime <= mtime + 1'b1;
            end
        end
    end

    // Read data, sampled at acceptance
    always_ff @(posedge clk) begin
        if (accept && !access_err && (cmd == MEM_CMD_RD)) begin
            case (addr[3:0])
                OFS_CTRL:     rdata <= {{(DMEM_DWIDTH-1){1'b0}}, timer_en};
                OFS_MTIME:    rdata <= mtime;
                default:      rdata <= mtimecmp;
            endcase
        end
    end

    // Compare interrupt
    assign irq = timer_en & (mtime >= mtimecmp);

endmodule

//--- rtl/dmem_tcm.sv
// Tightly coupled data RAM with single-cycle response
// Byte-lane writes and alignment check

`timescale 1ns/100ps

module dmem_tcm import dmem_pkg::*; #(
    parameter int TCM_DEPTH_WORDS = 256
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        req,
    input  logic        cmd,
    input  dmem_width_t width,
    input  dmem_addr_t  addr,
    input  dmem_data_t  wdata,
    output logic        req_ack,
    output dmem_data_t  rdata,
    output dmem_resp_t  resp
);

    // Depth is a power of two, so the modulo is a plain bit slice
    localparam int IDX_W = $clog2(TCM_DEPTH_WORDS);

    dmem_data_t       mem [TCM_DEPTH_WORDS];
    logic [IDX_W-1:0] word_idx;
    logic [3:0]       byte_en;
    logic             access_err;
    logic             accept;

    assign word_idx = addr[IDX_W+1:2];
    assign accept   = req & req_ack;

    // Lane enables and alignment
    always_comb begin
        byte_en    = 4'b0000;
        access_err = 1'b0;
        case (width)
            MEM_WIDTH_BYTE: begin
                byte_en = 4'b0001 << addr[1:0];
            end
            MEM_WIDTH_HWORD: begin
                byte_en    = 4'b0011 << addr[1:0];
                access_err = addr[0];
            end
            MEM_WIDTH_WORD: begin
                byte_en    = 4'b1111;
                access_err = |addr[1:0];
            end
            default: begin
                // Reserved size code
                access_err = 1'b1;
            end
        endcase
    end

    // Handshake and response
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            req_ack <= 1'b0;
            resp    <= MEM_RESP_NOTRDY;
        end else begin
            req_ack <= 1'b1;
            if (accept) begin
                resp <= access_err ? MEM_RESP_RDY_ER : MEM_RESP_RDY_OK;
            end else begin
                resp <= MEM_RESP_NOTRDY;
            end
        end
    end

    // Storage and read data
    always_ff @(posedge clk) begin
        if (accept && !access_err) begin
            if (cmd == MEM_CMD_RD) begin
                rdata <= mem[word_idx];
            end else begin
                for (int i = 0; i < 4; i++) begin
                    if (byte_en[i]) begin
                        mem[word_idx][i*8 +: 8] <= wdata[i*8 +: 8];
                    end
                end
            end
        end
    end

endmodule

//--- rtl/dmem_router.sv
// Data memory router with address decoder and two-phase FSM
// Steers core accesses to the TCM, timer or external port

`timescale 1ns/100ps

module dmem_router import dmem_pkg::*; #(
    parameter dmem_addr_t PORT1_ADDR_MASK    = 32'hFFFF0000,
    parameter dmem_addr_t PORT1_ADDR_PATTERN = 32'h00010000,
    parameter dmem_addr_t PORT2_ADDR_MASK    = 32'hFFFF0000,
    parameter dmem_addr_t PORT2_ADDR_PATTERN = 32'h00020000
) (
    input  logic        clk,
    input  logic        rst_n,

    // Core side
    input  logic        dmem_req,
    input  logic        dmem_cmd,
    input  dmem_width_t dmem_width,
    input  dmem_addr_t  dmem_addr,
    input  dmem_data_t  dmem_wdata,
    output logic        dmem_req_ack,
    output dmem_data_t  dmem_rdata,
    output dmem_resp_t  dmem_resp,

    // Port 0, default target
    output logic        port0_req,
    output logic        port0_cmd,
    output dmem_width_t port0_width,
    output dmem_addr_t  port0_addr,
    output dmem_data_t  port0_wdata,
    input  logic        port0_req_ack,
    input  dmem_data_t  port0_rdata,
    input  dmem_resp_t  port0_resp,

    // Port 1
    output logic        port1_req,
    output logic        port1_cmd,
    output dmem_width_t port1_width,
    output dmem_addr_t  port1_addr,
    output dmem_data_t  port1_wdata,
    input  logic        port1_req_ack,
    input  dmem_data_t  port1_rdata,
    input  dmem_resp_t  port1_resp,

    // Port 2
    output logic        port2_req,
    output logic        port2_cmd,
    output dmem_width_t port2_width,
    output dmem_addr_t  port2_addr,
    output dmem_data_t  port2_wdata,
    input  logic        port2_req_ack,
    input  dmem_data_t  port2_rdata,
    input  dmem_resp_t  port2_resp
);

    typedef enum logic {
        FSM_ADDR,
        FSM_DATA
    } fsm_state_e;

    typedef enum logic [1:0] {
        SEL_PORT0,
        SEL_PORT1,
        SEL_PORT2
    } port_sel_e;

    fsm_state_e fsm;
    port_sel_e  port_sel;
    port_sel_e  port_sel_r;
    logic       accept_window;
    logic       sel_req_ack;
    dmem_data_t sel_rdata;
    dmem_resp_t sel_resp;

    // ---------------------------------------------------------------------
    // Address decoder
    // ---------------------------------------------------------------------
    // Port 1 wins over port 2 when both windows match
    always_comb begin
        port_sel = SEL_PORT0;
        if ((dmem_addr & PORT1_ADDR_MASK) == PORT1_ADDR_PATTERN) begin
            port_sel = SEL_PORT1;
        end else if ((dmem_addr & PORT2_ADDR_MASK) == PORT2_ADDR_PATTERN) begin
            port_sel = SEL_PORT2;
        end
    end

    // ---------------------------------------------------------------------
    // Phase FSM
    // ---------------------------------------------------------------------
    // New address phase only when idle or in the RDY_OK cycle
    assign accept_window = (fsm == FSM_ADDR)
                         | ((fsm == FSM_DATA) & (sel_resp == MEM_RESP_RDY_OK));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fsm        <= FSM_ADDR;
            port_sel_r <= SEL_PORT0;
        end else begin
            case (fsm)
                FSM_ADDR: begin
                    if (dmem_req & sel_req_ack) begin
                        fsm        <= FSM_DATA;
                        port_sel_r <= port_sel;
                    end
                end
                FSM_DATA: begin
                    if (sel_resp == MEM_RESP_RDY_OK) begin
                        // overlapped acceptance keeps the data phase open
                        if (dmem_req & sel_req_ack) begin
                            port_sel_r <= port_sel;
                        end else begin
                            fsm <= FSM_ADDR;
                        end
                    end else if (sel_resp == MEM_RESP_RDY_ER) begin
                        fsm <= FSM_ADDR;
                    end
                end
                default: begin
                    fsm <= FSM_ADDR;
                end
            endcase
        end
    end

    // Acknowledge from the port being addressed now
    always_comb begin
        sel_req_ack = 1'b0;
        if (accept_window) begin
            case (port_sel)
                SEL_PORT0: sel_req_ack = port0_req_ack;
                SEL_PORT1: sel_req_ack = port1_req_ack;
                SEL_PORT2: sel_req_ack = port2_req_ack;
                default:   sel_req_ack = 1'b0;
            endcase
        end
    end

    // Response from the port registered at acceptance
    always_comb begin
        case (port_sel_r)
            SEL_PORT0: begin
                sel_rdata = port0_rdata;
                sel_resp  = port0_resp;
            end
            SEL_PORT1: begin
                sel_rdata = port1_rdata;
                sel_resp  = port1_resp;
            end
            SEL_PORT2: begin
                sel_rdata = port2_rdata;
                sel_resp  = port2_resp;
            end
            default: begin
                sel_rdata = '0;
                sel_resp  = MEM_RESP_RDY_ER;
            end
        endcase
    end

    // ---------------------------------------------------------------------
    // Core and port outputs
    // ---------------------------------------------------------------------
    assign dmem_req_ack = sel_req_ack;
    assign dmem_rdata   = sel_rdata;
    assign dmem_resp    = sel_resp;

    // Only req is gated, the fields go to every port
    assign port0_req = dmem_req & accept_window & (port_sel == SEL_PORT0);
    assign port1_req = dmem_req & accept_window & (port_sel == SEL_PORT1);
    assign port2_req = dmem_req & accept_window & (port_sel == SEL_PORT2);

    assign port0_cmd   = dmem_cmd;
    assign port0_width = dmem_width;
    assign port0_addr  = dmem_addr;
    assign port0_wdata = dmem_wdata;

    assign port1_cmd   = dmem_cmd;
    assign port1_width = dmem_width;
    assign port1_addr  = dmem_addr;
    assign port1_wdata = dmem_wdata;

    assign port2_cmd   = dmem_cmd;
    assign port2_width = dmem_width;
    assign port2_addr  = dmem_addr;
    assign port2_wdata = dmem_wdata;

endmodule

//--- rtl/dmem_pkg.sv
// Shared widths and vector types for the data memory subsystem
// Access size, response and command codes of the request/response protocol

package dmem_pkg;

    // ---------------------------------------------------------------------
    // Widths
    // ---------------------------------------------------------------------
    localparam int DMEM_AWIDTH = 32;
    localparam int DMEM_DWIDTH = 32;

    // Byte address and data word
    typedef logic [DMEM_AWIDTH-1:0] dmem_addr_t;
    typedef logic [DMEM_DWIDTH-1:0] dmem_data_t;

    // Access size code
    typedef logic [1:0] dmem_width_t;

    // Response code, driven by the target
    typedef logic [1:0] dmem_resp_t;

    // ---------------------------------------------------------------------
    // Codes
    // ---------------------------------------------------------------------
    localparam dmem_width_t MEM_WIDTH_BYTE  = 2'd0;
    localparam dmem_width_t MEM_WIDTH_HWORD = 2'd1;
    localparam dmem_width_t MEM_WIDTH_WORD  = 2'd2;

    localparam dmem_resp_t MEM_RESP_NOTRDY = 2'd0;
    localparam dmem_resp_t MEM_RESP_RDY_OK = 2'd1;
    localparam dmem_resp_t MEM_RESP_RDY_ER = 2'd2;

    // One-bit command
    localparam logic MEM_CMD_RD = 1'b0;
    localparam logic MEM_CMD_WR = 1'b1;

endpackage
